// ==== common/inv_params.svh ====
`ifndef INV_PARAMS_SVH
`define INV_PARAMS_SVH

// width of p and a
`define OPERAND_WIDTH 32

// bits per serial cycle
`define DIGIT_WIDTH 8
`define DIGIT_COUNT 5   // covers OPERAND_WIDTH+1 bits

// step count holds up to 2*OPERAND_WIDTH
`define COUNT_WIDTH 7

`endif

// ==== common/inv_pkg.sv ====
package inv_pkg;
  `include "inv_params.svh"

  typedef logic [`OPERAND_WIDTH-1:0] modulus_t;
  typedef logic [`OPERAND_WIDTH:0]   operand_t;   // one guard bit for r and s growth
  typedef logic [`COUNT_WIDTH-1:0]   count_t;

  typedef struct packed {
    operand_t u;
    operand_t v;
    operand_t r;
    operand_t s;
  } operands_t;

  typedef struct packed {
    operand_t x;
    operand_t y;
  } addsub_in_t;

  typedef enum logic [1:0] {
    SUB_U_V, SUB_V_U, SUB_R_P, SUB_P_R
  } sub_op_e;

  typedef enum logic [2:0] {
    UPD_HOLD, UPD_U_EVEN, UPD_V_EVEN, UPD_U_GT, UPD_V_GE, UPD_R_DIFF
  } upd_e;

  typedef enum logic [2:0] {
    IDLE, LOAD, STEP, WAIT_UNITS, RELEASE, REDUCE, FINAL, DONE
  } ctrl_state_e;

endpackage

// ==== rtl/serial_addsub.sv ====
`timescale 1ns/1ps
`include "inv_params.svh"

module serial_addsub #(
  parameter bit SUBTRACT = 1'b0
) (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                req,
  input  inv_pkg::addsub_in_t opnds,
  output logic                ack,
  output inv_pkg::operand_t   result
);
  localparam int LANE_W = `DIGIT_COUNT * `DIGIT_WIDTH;
  localparam int CNT_W  = $clog2(`DIGIT_COUNT);

  logic [LANE_W-1:0]       x_sh;
  logic [LANE_W-1:0]       y_sh;
  logic [LANE_W-1:0]       acc;
  logic [CNT_W-1:0]        digit_cnt;
  logic                    busy;
  logic                    carry;   // borrow kept as inverted carry
  logic [`DIGIT_WIDTH-1:0] y_dig;
  logic [`DIGIT_WIDTH:0]   dig_sum;

  assign y_dig   = SUBTRACT ? ~y_sh[`DIGIT_WIDTH-1:0] : y_sh[`DIGIT_WIDTH-1:0];
  assign dig_sum = {1'b0, x_sh[`DIGIT_WIDTH-1:0]} + {1'b0, y_dig}
                 + {{`DIGIT_WIDTH{1'b0}}, carry};
  assign result  = acc[`OPERAND_WIDTH:0];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy      <= 1'b0;
      ack       <= 1'b0;
      carry     <= 1'b0;
      digit_cnt <= '0;
    end else if (busy) begin
      carry     <= dig_sum[`DIGIT_WIDTH];
      digit_cnt <= digit_cnt + 1'b1;
      if (digit_cnt == CNT_W'(`DIGIT_COUNT - 1)) begin
        busy <= 1'b0;
        ack  <= 1'b1;   // last digit lands with ack
      end
    end else if (ack) begin
      if (!req) ack <= 1'b0;
    end else if (req) begin
      busy      <= 1'b1;
      carry     <= SUBTRACT;   // +1 completes two's complement
      digit_cnt <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!busy && !ack && req) begin
      x_sh <= LANE_W'(opnds.x);
      y_sh <= LANE_W'(opnds.y);
    end else if (busy) begin
      x_sh <= x_sh >> `DIGIT_WIDTH;
      y_sh <= y_sh >> `DIGIT_WIDTH;
      acc  <= {dig_sum[`DIGIT_WIDTH-1:0], acc[LANE_W-1:`DIGIT_WIDTH]};
    end
  end

endmodule

// ==== rtl/operand_bank.sv ====
`timescale 1ns/1ps

module operand_bank (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                load,
  input  inv_pkg::modulus_t   p,
  input  inv_pkg::modulus_t   a,
  input  inv_pkg::upd_e       upd,
  input  inv_pkg::sub_op_e    sub_op,
  input  inv_pkg::operand_t   diff,
  input  inv_pkg::operand_t   sum,
  output inv_pkg::operands_t  ops,
  output inv_pkg::addsub_in_t sub_in,
  output inv_pkg::addsub_in_t add_in
);
  import inv_pkg::*;

  operands_t st;
  operand_t  p_ext;

  assign p_ext    = {1'b0, p};
  assign ops      = st;
  assign add_in.x = st.r;   // sigma always r+s
  assign add_in.y = st.s;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      st <= '0;
    end else if (load) begin
      st.u <= p_ext;
      st.v <= {1'b0, a};
      st.r <= '0;
      st.s <= operand_t'(1);
    end else begin
      case (upd)
        UPD_U_EVEN: begin
          st.u <= st.u >> 1;
          st.s <= st.s << 1;
        end
        UPD_V_EVEN: begin
          st.v <= st.v >> 1;
          st.r <= st.r << 1;
        end
        UPD_U_GT: begin
          st.u <= diff >> 1;   // (u-v)/2
          st.r <= sum;
          st.s <= st.s << 1;
        end
        UPD_V_GE: begin
          st.v <= diff >> 1;   // (v-u)/2
          st.s <= sum;
          st.r <= st.r << 1;
        end
        UPD_R_DIFF: st.r <= diff;
        default: st <= st;
      endcase
    end
  end

  always_comb begin
    case (sub_op)
      SUB_U_V: begin sub_in.x = st.u;  sub_in.y = st.v;  end
      SUB_V_U: begin sub_in.x = st.v;  sub_in.y = st.u;  end
      SUB_R_P: begin sub_in.x = st.r;  sub_in.y = p_ext; end
      default: begin sub_in.x = p_ext; sub_in.y = st.r;  end
    endcase
  end

endmodule

// ==== inv_control/inv_control.sv ====
`timescale 1ns/1ps

module inv_control (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               req,
  input  inv_pkg::modulus_t  p,
  input  inv_pkg::operands_t ops,
  input  logic               sub_ack,
  input  logic               add_ack,
  output logic               ack,
  output logic               load,
  output logic               sub_req,
  output logic               add_req,
  output inv_pkg::sub_op_e   sub_op,
  output inv_pkg::upd_e      upd,
  output inv_pkg::count_t    k
);
  import inv_pkg::*;

  ctrl_state_e state;
  ctrl_state_e state_nx;
  sub_op_e     sub_op_nx;
  logic        sub_req_nx;
  logic        add_req_nx;
  logic        ack_nx;
  logic        k_inc;
  logic        v_zero;
  logic        u_gt_v;
  logic        r_ge_p;
  logic        units_ack;
  logic        units_idle;

  assign v_zero     = (ops.v == '0);
  assign u_gt_v     = (ops.u > ops.v);
  assign r_ge_p     = (ops.r >= {1'b0, p});
  assign units_ack  = sub_ack & add_ack;
  assign units_idle = !sub_ack && !add_ack;

  always_comb begin
    state_nx   = state;
    sub_op_nx  = sub_op;
    sub_req_nx = sub_req;
    add_req_nx = add_req;
    ack_nx     = ack;
    load       = 1'b0;
    upd        = UPD_HOLD;
    k_inc      = 1'b0;
    case (state)
      IDLE: if (req) state_nx = LOAD;
      LOAD: begin
        load     = 1'b1;
        state_nx = STEP;
      end
      STEP: begin
        if (v_zero) begin
          // loop over, go to correction
          sub_req_nx = 1'b1;
          sub_op_nx  = r_ge_p ? SUB_R_P : SUB_P_R;
          state_nx   = r_ge_p ? REDUCE : FINAL;
        end else if (!ops.u[0]) begin
          upd   = UPD_U_EVEN;
          k_inc = 1'b1;
        end else if (!ops.v[0]) begin
          upd   = UPD_V_EVEN;
          k_inc = 1'b1;
        end else begin
          sub_op_nx  = u_gt_v ? SUB_U_V : SUB_V_U;
          sub_req_nx = 1'b1;
          add_req_nx = 1'b1;
          state_nx   = WAIT_UNITS;
        end
      end
      WAIT_UNITS: if (units_ack) begin
        upd        = (sub_op == SUB_U_V) ? UPD_U_GT : UPD_V_GE;
        k_inc      = 1'b1;
        sub_req_nx = 1'b0;
        add_req_nx = 1'b0;
        state_nx   = RELEASE;
      end
      REDUCE, FINAL: if (sub_ack) begin
        upd        = UPD_R_DIFF;
        sub_req_nx = 1'b0;
        state_nx   = RELEASE;
      end
      RELEASE: if (units_idle) begin
        case (sub_op)   // last op tells where we came from
          SUB_R_P: begin
            sub_op_nx  = SUB_P_R;
            sub_req_nx = 1'b1;
            state_nx   = FINAL;
          end
          SUB_P_R: begin
            ack_nx   = 1'b1;
            state_nx = DONE;
          end
          default: state_nx = STEP;
        endcase
      end
      DONE: if (!req) begin
        ack_nx   = 1'b0;
        state_nx = IDLE;
      end
      default: state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state   <= IDLE;
      sub_op  <= SUB_U_V;
      sub_req <= 1'b0;
      add_req <= 1'b0;
      ack     <= 1'b0;
      k       <= '0;
    end else begin
      state   <= state_nx;
      sub_op  <= sub_op_nx;
      sub_req <= sub_req_nx;
      add_req <= add_req_nx;
      ack     <= ack_nx;
      if (state == LOAD) k <= '0;
      else if (k_inc) k <= k + 1'b1;
    end
  end

endmodule

// ==== rtl/inv_top.sv ====
`timescale 1ns/1ps
`include "inv_params.svh"

module inv_top (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              req,
  input  inv_pkg::modulus_t p,
  input  inv_pkg::modulus_t a,
  output logic              ack,
  output inv_pkg::modulus_t inv,
  output inv_pkg::count_t   k
);
  import inv_pkg::*;

  operands_t  ops;
  addsub_in_t sub_in;
  addsub_in_t add_in;
  operand_t   diff;
  operand_t   sum;
  sub_op_e    sub_op;
  upd_e       upd;
  logic       load;
  logic       sub_req;
  logic       add_req;
  logic       sub_ack;
  logic       add_ack;

  assign inv = ops.r[`OPERAND_WIDTH-1:0];   // r holds p-r after FINAL

  inv_control u_control (
    .clk     (clk),     .reset_n (reset_n), .req     (req),
    .p       (p),       .ops     (ops),
    .sub_ack (sub_ack), .add_ack (add_ack),
    .ack     (ack),     .load    (load),
    .sub_req (sub_req), .add_req (add_req),
    .sub_op  (sub_op),  .upd     (upd),     .k       (k)
  );

  operand_bank u_bank (
    .clk     (clk),     .reset_n (reset_n), .load    (load),
    .p       (p),       .a       (a),
    .upd     (upd),     .sub_op  (sub_op),
    .diff    (diff),    .sum     (sum),
    .ops     (ops),     .sub_in  (sub_in),  .add_in  (add_in)
  );

  serial_addsub #(.SUBTRACT(1'b1)) u_delta (
    .clk     (clk),     .reset_n (reset_n), .req     (sub_req),
    .opnds   (sub_in),  .ack     (sub_ack), .result  (diff)
  );

  serial_addsub #(.SUBTRACT(1'b0)) u_sigma (
    .clk     (clk),     .reset_n (reset_n), .req     (add_req),
    .opnds   (add_in),  .ack     (add_ack), .result  (sum)
  );

endmodule

// ==== testbench/tb_inv.sv ====
`timescale 1ns/1ps
`include "inv_params.svh"

module tb_inv;
  import inv_pkg::*;

  localparam int       TIMEOUT_CYCLES = 2000;
  localparam modulus_t BIG_PRIME      = 32'd4294967291;

  logic     clk;
  logic     reset_n;
  logic     req;
  modulus_t p;
  modulus_t a;
  logic     ack;
  modulus_t inv;
  count_t   k;
  int       mismatch_count;
  int       timeout_count;

  inv_top i_dut (
    .clk (clk), .reset_n (reset_n), .req (req), .p (p), .a (a),
    .ack (ack), .inv (inv), .k (k)
  );

  always #10 clk = ~clk;

  function automatic int bit_length(input modulus_t value);
    int n;
    int i;
    n = 0;
    for (i = 0; i < `OPERAND_WIDTH; i++) if (value[i]) n = i + 1;
    return n;
  endfunction

  task automatic check_flag(input logic actual, input logic expected, input string what);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %b expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_modulus(input modulus_t actual, input modulus_t expected,
                               input string what);
    if (actual !== expected) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %0d expected %0d", $time, what, actual, expected);
    end
  endtask

  task automatic check_count(input count_t actual, input count_t lo, input count_t hi,
                             input string what);
    if ($isunknown(actual) || actual < lo || actual > hi) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s got %0d expected %0d..%0d", $time, what, actual, lo, hi);
    end
  endtask

  // polls on falling edges, where DUT outputs are settled
  task automatic wait_ack(input logic level, input string what, output bit ok);
    int cycles;
    cycles = 0;
    while (ack !== level && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    ok = (ack === level);
    if (!ok) begin
      timeout_count++;
      $display("Timeout at %0t: ack never went to %b while %s", $time, level, what);
    end
  endtask

  // inv*a must equal 2^k mod p, inv below p, k within n..2n
  task automatic check_result(input modulus_t pv, input modulus_t av);
    longint unsigned pw;
    longint unsigned prod;
    int              n;
    int              i;
    n  = bit_length(pv);
    pw = 1;
    for (i = 0; i < int'(k); i++) pw = (pw * 2) % pv;
    prod = (longint'(inv) * longint'(av)) % pv;
    check_modulus(modulus_t'(prod), modulus_t'(pw), $sformatf("inv*a mod %0d", pv));
    check_modulus(modulus_t'(longint'(inv) % pv), inv, "inv below p");
    check_count(k, count_t'(n), count_t'(2 * n), "step count k");
  endtask

  // called on a falling edge, returns on one
  task automatic run_inverse(input modulus_t pv, input modulus_t av, input int hold_cycles);
    bit       ok;
    modulus_t held_inv;
    count_t   held_k;
    p   = pv;
    a   = av;
    req = 1'b1;
    wait_ack(1'b1, $sformatf("computing p=%0d a=%0d", pv, av), ok);
    if (ok) begin
      check_result(pv, av);
      held_inv = inv;
      held_k   = k;
      repeat (hold_cycles) begin
        @(negedge clk);
        check_flag(ack, 1'b1, "ack under back-pressure");
        check_modulus(inv, held_inv, "inv under back-pressure");
        check_count(k, held_k, held_k, "k under back-pressure");
      end
    end
    req = 1'b0;
    wait_ack(1'b0, "releasing the request", ok);
  endtask

  task automatic reset_and_idle();
    repeat (3) @(posedge clk);
    check_flag(ack, 1'b0, "ack in reset");
    @(negedge clk);
    reset_n = 1'b1;
    repeat (10) begin
      @(negedge clk);
      check_flag(ack, 1'b0, "ack before first request");
    end
  endtask

  task automatic small_primes();
    modulus_t primes [3];
    int       i;
    primes = '{32'd11, 32'd13, 32'd251};
    for (i = 0; i < 3; i++) begin
      run_inverse(primes[i], 32'd1, 0);
      run_inverse(primes[i], 32'd2, 0);
      run_inverse(primes[i], primes[i] - 1, 0);
    end
  endtask

  task automatic large_prime();
    modulus_t av;
    int       i;
    for (i = 0; i < 20; i++) begin
      av = 32'd1 + ($urandom % (BIG_PRIME - 32'd1));   // 1..p-1
      run_inverse(BIG_PRIME, av, 0);
    end
  endtask

  task automatic back_to_back();
    run_inverse(32'd251, 32'd200, 0);
    run_inverse(BIG_PRIME, 32'd3, 0);
    run_inverse(32'd13, 32'd12, 0);
    run_inverse(32'd65521, 32'd40000, 0);
  endtask

  initial begin
    clk            = 1'b0;
    reset_n        = 1'b0;
    req            = 1'b0;
    p              = '0;
    a              = '0;
    mismatch_count = 0;
    timeout_count  = 0;
    void'($urandom(32'h290f_86f6));

    reset_and_idle();
    small_primes();
    large_prime();
    run_inverse(BIG_PRIME, 32'h1234_5677, 15);   // held req past ack
    back_to_back();

    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+common
common/inv_pkg.sv
rtl/serial_addsub.sv
rtl/operand_bank.sv
inv_control/inv_control.sv
rtl/inv_top.sv
testbench/tb_inv.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the modular inverse testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tb_inv_sim

verilator --binary --timing --timescale 1ns/1ps \
  -f compile.f --top-module tb_inv -o "$BIN"
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
  echo "no verdict found in $LOG"
  exit 1
fi
exit 0
